// File: trace_monitor_pkg.sv
// trace monitor shared definitions
// control register addresses and instruction constants
`default_nettype none

package trace_monitor_pkg;

    // control register map, one word per register
    typedef enum logic [3:0] {
        TRIG_START_EN   = 4'h0,
        TRIG_END_EN     = 4'h1,
        TRIG_START_ADDR = 4'h2,
        TRIG_END_ADDR   = 4'h3,
        RANGE_LO_EN     = 4'h4,
        RANGE_HI_EN     = 4'h5,
        RANGE_LO        = 4'h6,
        RANGE_HI        = 4'h7
    } ctrl_addr_t;

    // RV32 instruction word
    localparam int INSTR_WIDTH = 32;

    // wfi encoding (SYSTEM opcode, funct12 0x105)
    localparam logic [INSTR_WIDTH-1:0] WFI_INSTRUCTION = 32'h1050_0073;

endpackage

`default_nettype wire

// File: ctrl_regs.sv
// control register file of the trace monitor
// holds trigger and range settings, written through a strobe
// that acts on its rising edge or on its level
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs #(
    parameter int XLEN          = 32,
    parameter bit WRITE_ON_EDGE = 1'b1
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire trace_monitor_pkg::ctrl_addr_t ctrl_addr,
    input  wire logic [XLEN-1:0]               ctrl_wdata,
    input  wire logic                          ctrl_write_enable,
    output logic                               start_en,
    output logic                               end_en,
    output logic [XLEN-1:0]                    start_addr,
    output logic [XLEN-1:0]                    end_addr,
    output logic                               lo_en,
    output logic                               hi_en,
    output logic [XLEN-1:0]                    lo_bound,
    output logic [XLEN-1:0]                    hi_bound
);
    import trace_monitor_pkg::*;

    logic we_q;
    logic wr;

    // previous strobe value for the edge detector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ctrl_write_enable;
        end
    end

    // one pulse per rise in edge mode, otherwise every cycle the strobe is high
    assign wr = WRITE_ON_EDGE ? (ctrl_write_enable & ~we_q) : ctrl_write_enable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_en   <= 1'b0;
            end_en     <= 1'b0;
            start_addr <= '0;
            end_addr   <= '1;
            lo_en      <= 1'b0;
            hi_en      <= 1'b0;
            lo_bound   <= '0;
            hi_bound   <= '1;
        end else if (wr) begin
            case (ctrl_addr)
                TRIG_START_EN:   start_en   <= ctrl_wdata[0];
                TRIG_END_EN:     end_en     <= ctrl_wdata[0];
                TRIG_START_ADDR: start_addr <= ctrl_wdata;
                TRIG_END_ADDR:   end_addr   <= ctrl_wdata;
                RANGE_LO_EN:     lo_en      <= ctrl_wdata[0];
                RANGE_HI_EN:     hi_en      <= ctrl_wdata[0];
                RANGE_LO:        lo_bound   <= ctrl_wdata;
                RANGE_HI:        hi_bound   <= ctrl_wdata;
                // unmapped codes are dropped
                default: ;
            endcase
        end
    end

    // a held strobe must not keep rewriting the trigger address
    a_start_addr_only_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!ctrl_write_enable || (WRITE_ON_EDGE && $past(ctrl_write_enable)))
            |=> $stable(start_addr)
    );

endmodule

`default_nettype wire

// File: pc_tracker.sv
// program counter history of the trace monitor
// flags a finished instruction when the PC moves on, and forces
// one record for a wfi that stays in the history long enough
`timescale 1ns/1ns
`default_nettype none

module pc_tracker #(
    parameter int XLEN     = 32,
    parameter int WFI_HOLD = 8
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic [XLEN-1:0]                        pc,
    input  wire logic [trace_monitor_pkg::INSTR_WIDTH-1:0] instr,
    output logic [XLEN-1:0]                             hist_pc,
    output logic [trace_monitor_pkg::INSTR_WIDTH-1:0]   hist_instr,
    output logic                                        retire,
    output logic                                        wfi_stopped
);
    import trace_monitor_pkg::*;

    localparam int CNT_W = $clog2(WFI_HOLD + 1);

    logic [XLEN-1:0]        pc_s0;
    logic [INSTR_WIDTH-1:0] instr_s0;
    logic [CNT_W-1:0]       wfi_cnt;
    logic                   hist_is_wfi;

    // stage 0 samples the core, history follows one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_s0      <= '0;
            instr_s0   <= '0;
            hist_pc    <= '0;
            hist_instr <= '0;
        end else begin
            pc_s0      <= pc;
            instr_s0   <= instr;
            hist_pc    <= pc_s0;
            hist_instr <= instr_s0;
        end
    end

    assign hist_is_wfi = (hist_instr == WFI_INSTRUCTION);

    // wfi hold counter, stops at WFI_HOLD
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wfi_cnt <= '0;
        end else if (!hist_is_wfi) begin
            wfi_cnt <= '0;
        end else if (wfi_cnt < WFI_HOLD) begin
            wfi_cnt <= wfi_cnt + 1'b1;
        end
    end

    assign wfi_stopped = (wfi_cnt == WFI_HOLD);

    // the older instruction is done once the PC behind it changes,
    // pc zero means the core has not started yet
    assign retire = ((pc_s0 != hist_pc) || (wfi_cnt == WFI_HOLD - 1))
                    && (hist_pc != '0);

    // a zero pc two cycles back is what the history holds now
    a_no_retire_at_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(pc, 2) == '0) |-> !retire
    );

endmodule

`default_nettype wire

// File: trace_gate.sv
// record filter of the trace monitor
// combines trigger state, address range, enable and wfi stop
// into the strobe that writes a record
`timescale 1ns/1ns
`default_nettype none

module trace_gate #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] hist_pc,
    input  wire logic            retire,
    input  wire logic            wfi_stopped,
    input  wire logic            en,
    input  wire logic            start_en,
    input  wire logic            end_en,
    input  wire logic [XLEN-1:0] start_addr,
    input  wire logic [XLEN-1:0] end_addr,
    input  wire logic            lo_en,
    input  wire logic            hi_en,
    input  wire logic [XLEN-1:0] lo_bound,
    input  wire logic [XLEN-1:0] hi_bound,
    output logic                 record_write
);
    logic started;
    logic ended;
    logic trig_ok;
    logic range_ok;

    // triggers compare against the live pc,
    // an end match in the same cycle wins over a start match
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
            ended   <= 1'b0;
        end else begin
            if (start_en && (pc == start_addr)) begin
                started <= 1'b1;
                ended   <= 1'b0;
            end
            if (end_en && (pc == end_addr)) begin
                ended   <= 1'b1;
                started <= 1'b0;
            end
        end
    end

    assign trig_ok = (!start_en || started) && (!end_en || !ended);

    // both bounds are inclusive
    assign range_ok = (!lo_en || (hist_pc >= lo_bound))
                      && (!hi_en || (hist_pc <= hi_bound));

    assign record_write = retire && en && !wfi_stopped && trig_ok && range_ok;

endmodule

`default_nettype wire

// File: delta_timer.sv
// cycle delta timer of the trace monitor
// counts cycles since the last record write, saturating at all ones
`timescale 1ns/1ns
`default_nettype none

module delta_timer #(
    parameter int DELTA_WIDTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   record_write,
    output logic [DELTA_WIDTH-1:0]      delta
);
    logic [DELTA_WIDTH-1:0] cycles;

    // restarts at one so the next write sees the full distance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycles <= '0;
        end else if (record_write) begin
            cycles <= {{(DELTA_WIDTH-1){1'b0}}, 1'b1};
        end else if (cycles != '1) begin
            cycles <= cycles + 1'b1;
        end
    end

    assign delta = cycles;

endmodule

`default_nettype wire

// File: trace_fifo.sv
// record FIFO of the trace monitor
// circular buffer with a last flag per entry, valid/ready output
// and a sticky overflow flag for writes lost while full
`timescale 1ns/1ns
`default_nettype none

module trace_fifo #(
    parameter int XLEN        = 32,
    parameter int DELTA_WIDTH = 16,
    parameter int FIFO_DEPTH  = 8
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push,
    input  wire logic [trace_monitor_pkg::INSTR_WIDTH+DELTA_WIDTH+XLEN-1:0] push_data,
    input  wire logic push_last,
    input  wire logic m_tready,
    output logic      m_tvalid,
    output logic [trace_monitor_pkg::INSTR_WIDTH+DELTA_WIDTH+XLEN-1:0] m_tdata,
    output logic      m_tlast,
    output logic      overflow
);
    import trace_monitor_pkg::*;

    localparam int REC_W = INSTR_WIDTH + DELTA_WIDTH + XLEN;
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [REC_W-1:0] rec_mem [FIFO_DEPTH];
    logic             last_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == FIFO_DEPTH);
    assign do_push = push && !full;
    assign do_pop  = m_tvalid && m_tready;

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            rec_mem[wr_ptr]  <= push_data;
            last_mem[wr_ptr] <= push_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // stays set until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assign m_tvalid = (count != '0);
    assign m_tdata  = rec_mem[rd_ptr];
    assign m_tlast  = m_tvalid && last_mem[rd_ptr];

    // a stalled beat holds until the sink takes it
    a_stream_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata))
    );

endmodule

`default_nettype wire

// File: trace_monitor.sv
// instruction trace monitor for a RISC-V core
// emits one record per finished instruction: instruction, cycle delta
// and PC, filtered by triggers and range, on a valid/ready stream
`timescale 1ns/1ns
`default_nettype none

module trace_monitor #(
    parameter int XLEN          = 32,
    parameter int DELTA_WIDTH   = 16,
    parameter int WFI_HOLD      = 8,
    parameter int FIFO_DEPTH    = 8,
    parameter bit WRITE_ON_EDGE = 1'b1
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [trace_monitor_pkg::INSTR_WIDTH-1:0] instr,
    input  wire logic en,
    input  wire trace_monitor_pkg::ctrl_addr_t ctrl_addr,
    input  wire logic [XLEN-1:0] ctrl_wdata,
    input  wire logic ctrl_write_enable,
    input  wire logic m_tready,
    output logic      m_tvalid,
    output logic [trace_monitor_pkg::INSTR_WIDTH+DELTA_WIDTH+XLEN-1:0] m_tdata,
    output logic      m_tlast,
    output logic      overflow
);
    import trace_monitor_pkg::*;

    logic                   start_en;
    logic                   end_en;
    logic [XLEN-1:0]        start_addr;
    logic [XLEN-1:0]        end_addr;
    logic                   lo_en;
    logic                   hi_en;
    logic [XLEN-1:0]        lo_bound;
    logic [XLEN-1:0]        hi_bound;
    logic [XLEN-1:0]        hist_pc;
    logic [INSTR_WIDTH-1:0] hist_instr;
    logic                   retire;
    logic                   wfi_stopped;
    logic                   record_write;
    logic [DELTA_WIDTH-1:0] delta;
    logic [INSTR_WIDTH+DELTA_WIDTH+XLEN-1:0] push_data;
    logic                   push_last;

    ctrl_regs #(
        .XLEN          (XLEN),
        .WRITE_ON_EDGE (WRITE_ON_EDGE)
    ) ctrl_regs_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .start_en          (start_en),
        .end_en            (end_en),
        .start_addr        (start_addr),
        .end_addr          (end_addr),
        .lo_en             (lo_en),
        .hi_en             (hi_en),
        .lo_bound          (lo_bound),
        .hi_bound          (hi_bound)
    );

    pc_tracker #(
        .XLEN     (XLEN),
        .WFI_HOLD (WFI_HOLD)
    ) pc_tracker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .instr       (instr),
        .hist_pc     (hist_pc),
        .hist_instr  (hist_instr),
        .retire      (retire),
        .wfi_stopped (wfi_stopped)
    );

    trace_gate #(
        .XLEN (XLEN)
    ) trace_gate_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .hist_pc      (hist_pc),
        .retire       (retire),
        .wfi_stopped  (wfi_stopped),
        .en           (en),
        .start_en     (start_en),
        .end_en       (end_en),
        .start_addr   (start_addr),
        .end_addr     (end_addr),
        .lo_en        (lo_en),
        .hi_en        (hi_en),
        .lo_bound     (lo_bound),
        .hi_bound     (hi_bound),
        .record_write (record_write)
    );

    delta_timer #(
        .DELTA_WIDTH (DELTA_WIDTH)
    ) delta_timer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .record_write (record_write),
        .delta        (delta)
    );

    // record layout, msb first: instruction, delta, pc
    assign push_data = {hist_instr, delta, hist_pc};

    // the forced wfi record closes the trace
    assign push_last = (hist_instr == WFI_INSTRUCTION);

    trace_fifo #(
        .XLEN        (XLEN),
        .DELTA_WIDTH (DELTA_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) trace_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (record_write),
        .push_data (push_data),
        .push_last (push_last),
        .m_tready  (m_tready),
        .m_tvalid  (m_tvalid),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

// File: tb_trace_monitor.sv
// self-checking testbench of the trace monitor
// runs PC programs through the filters and compares every stream beat
// against a record model kept in a queue
`timescale 1ns/1ns
`default_nettype none

module tb_trace_monitor;
    import trace_monitor_pkg::*;

    localparam int XLEN        = 32;
    localparam int DELTA_WIDTH = 16;
    localparam int REC_W       = INSTR_WIDTH + DELTA_WIDTH + XLEN;
    localparam int FIFO_DEPTH  = 8;
    localparam int WFI_HOLD    = 8;
    localparam int MAX_DELTA   = (1 << DELTA_WIDTH) - 1;
    localparam int PC_HOLD     = 5;
    // well past the wfi hold count of the DUT
    localparam int WFI_CYCLES  = 20;
    localparam int IDLE_CYCLES = 6;
    localparam int MAX_PCS     = 16;
    localparam int DRAIN_LIMIT = 400;
    localparam logic [31:0] SEED = 32'h9bf9_15cc;

    typedef struct packed {
        logic             last;
        logic [REC_W-1:0] mask;
        logic [REC_W-1:0] data;
    } exp_rec_t;

    typedef enum {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_t;

    logic                   clk;
    logic                   rst_n;
    logic [XLEN-1:0]        pc;
    logic [INSTR_WIDTH-1:0] instr;
    logic                   en;
    ctrl_addr_t             ctrl_addr;
    logic [XLEN-1:0]        ctrl_wdata;
    logic                   ctrl_write_enable;
    logic                   m_tready;
    logic                   m_tvalid;
    logic [REC_W-1:0]       m_tdata;
    logic                   m_tlast;
    logic                   overflow;

    ready_mode_t     ready_mode;
    string           test_name;
    exp_rec_t        exp_q [$];
    logic            exp_valid;
    logic [REC_W-1:0] exp_data;
    logic [REC_W-1:0] exp_mask;
    logic            exp_last;
    int              cycle_cnt;
    // edge of the previous record write, negative until the first one
    int              last_write;

    // mirror of the configuration and trigger state
    logic            m_en;
    logic            m_start_en;
    logic            m_end_en;
    logic [XLEN-1:0] m_start_addr;
    logic [XLEN-1:0] m_end_addr;
    logic            m_lo_en;
    logic            m_hi_en;
    logic [XLEN-1:0] m_lo;
    logic [XLEN-1:0] m_hi;
    logic            m_started;
    logic            m_ended;

    trace_monitor trace_monitor_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .pc                (pc),
        .instr             (instr),
        .en                (en),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .m_tready          (m_tready),
        .m_tvalid          (m_tvalid),
        .m_tdata           (m_tdata),
        .m_tlast           (m_tlast),
        .overflow          (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic void load_head();
        if (exp_q.size() > 0) begin
            exp_valid = 1'b1;
            exp_data  = exp_q[0].data;
            exp_mask  = exp_q[0].mask;
            exp_last  = exp_q[0].last;
        end else begin
            exp_valid = 1'b0;
        end
    endfunction

    // end match applied after start match, so end wins
    function automatic void update_trig(input logic [XLEN-1:0] live_pc);
        if (m_start_en && (live_pc == m_start_addr)) begin
            m_started = 1'b1;
            m_ended   = 1'b0;
        end
        if (m_end_en && (live_pc == m_end_addr)) begin
            m_ended   = 1'b1;
            m_started = 1'b0;
        end
    endfunction

    function automatic bit gate_pass(input logic [XLEN-1:0] rec_pc);
        bit trig_ok;
        bit range_ok;
        trig_ok  = (!m_start_en || m_started) && (!m_end_en || !m_ended);
        range_ok = (!m_lo_en || (rec_pc >= m_lo)) && (!m_hi_en || (rec_pc <= m_hi));
        return m_en && trig_ok && range_ok;
    endfunction

    // cycles between two record writes, saturating like the counter
    function automatic int delta_since(input int write_cycle);
        int gap;
        if (last_write < 0) begin
            return -1;
        end
        gap = write_cycle - last_write;
        return (gap > MAX_DELTA) ? MAX_DELTA : gap;
    endfunction

    // a negative delta means the distance to the previous record is unknown
    function automatic void expect_record(input logic [INSTR_WIDTH-1:0] rec_instr,
            input logic [XLEN-1:0] rec_pc, input int delta, input logic last);
        exp_rec_t rec;
        rec.data = {rec_instr, DELTA_WIDTH'(delta), rec_pc};
        rec.mask = '1;
        if (delta < 0) begin
            rec.mask[XLEN +: DELTA_WIDTH] = '0;
        end
        rec.last = last;
        exp_q.push_back(rec);
        load_head();
    endfunction

    task automatic write_reg(input ctrl_addr_t addr, input logic [XLEN-1:0] data,
            input int hold);
        int i;
        ctrl_addr         = addr;
        ctrl_wdata        = data;
        ctrl_write_enable = 1'b1;
        tick();
        // later data under a held strobe must be ignored
        for (i = 1; i < hold; i++) begin
            ctrl_wdata = ~data;
            tick();
        end
        ctrl_write_enable = 1'b0;
        tick();
        case (addr)
            TRIG_START_EN:   m_start_en   = data[0];
            TRIG_END_EN:     m_end_en     = data[0];
            TRIG_START_ADDR: m_start_addr = data;
            TRIG_END_ADDR:   m_end_addr   = data;
            RANGE_LO_EN:     m_lo_en      = data[0];
            RANGE_HI_EN:     m_hi_en      = data[0];
            RANGE_LO:        m_lo         = data;
            RANGE_HI:        m_hi         = data;
            default: ;
        endcase
    endtask

    task automatic run_program(input logic [XLEN-1:0] base, input int n,
            input bit with_wfi, input int max_checked);
        logic [INSTR_WIDTH-1:0] instrs [MAX_PCS];
        logic [XLEN-1:0]        wfi_pc;
        logic [XLEN-1:0]        next_pc;
        logic [XLEN-1:0]        cur_pc;
        int                     start_cycle;
        int                     write_cycle;
        int                     checked;
        int                     i;
        wfi_pc      = base + XLEN'(4 * n);
        start_cycle = cycle_cnt;
        checked     = 0;
        for (i = 0; i < n; i++) begin
            instrs[i] = $urandom;
            if (instrs[i] == WFI_INSTRUCTION) begin
                instrs[i] = ~instrs[i];
            end
        end
        // a pc retires one cycle after its successor goes live,
        // so the successor's trigger match already counts for it
        update_trig(base);
        for (i = 0; i < n; i++) begin
            cur_pc = base + XLEN'(4 * i);
            if (i < n - 1) begin
                next_pc = base + XLEN'(4 * (i + 1));
            end else if (with_wfi) begin
                next_pc = wfi_pc;
            end else begin
                next_pc = '0;
            end
            update_trig(next_pc);
            if (gate_pass(cur_pc)) begin
                // stored two edges after the successor goes live
                write_cycle = start_cycle + (i + 1) * PC_HOLD + 2;
                if (checked < max_checked) begin
                    expect_record(instrs[i], cur_pc, delta_since(write_cycle), 1'b0);
                end
                checked++;
                last_write = write_cycle;
            end
        end
        if (with_wfi && gate_pass(wfi_pc)) begin
            // forced once the hold counter reaches WFI_HOLD - 1
            write_cycle = start_cycle + n * PC_HOLD + WFI_HOLD + 2;
            if (checked < max_checked) begin
                expect_record(WFI_INSTRUCTION, wfi_pc, delta_since(write_cycle), 1'b1);
            end
            last_write = write_cycle;
        end
        update_trig('0);
        for (i = 0; i < n; i++) begin
            pc    = base + XLEN'(4 * i);
            instr = instrs[i];
            repeat (PC_HOLD) tick();
        end
        if (with_wfi) begin
            pc    = wfi_pc;
            instr = WFI_INSTRUCTION;
            repeat (WFI_CYCLES) tick();
        end
        pc    = '0;
        instr = '0;
        repeat (IDLE_CYCLES) tick();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            if (waited >= DRAIN_LIMIT) begin
                abort_run($sformatf("timeout in test %s: %0d expected records never arrived",
                                    test_name, exp_q.size()));
            end
            tick();
            waited++;
        end
    endtask

    task automatic check_overflow(input logic expected);
        a_overflow_value: assert (overflow == expected) else begin
            abort_run($sformatf("FAILED %s expected overflow %b actual %b",
                                test_name, expected, overflow));
        end
    endtask

    always @(posedge clk) begin
        #2;
        case (ready_mode)
            READY_RANDOM: m_tready = (($urandom % 4) != 0);
            READY_LOW:    m_tready = 1'b0;
            default:      m_tready = 1'b1;
        endcase
    end

    // retire the head once its beat has transferred
    always @(posedge clk) begin
        if (rst_n && m_tvalid && m_tready && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
            load_head();
        end
    end

    a_beat_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_tvalid && m_tready) |-> exp_valid
    ) else begin
        abort_run($sformatf("a record arrived in test %s while none was expected", test_name));
    end

    a_beat_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_tvalid && m_tready && exp_valid)
            |-> ((((m_tdata ^ exp_data) & exp_mask) == '0) && (m_tlast == exp_last))
    ) else begin
        abort_run($sformatf("FAILED %s expected %h last %b actual %h last %b", test_name,
                            $sampled(exp_data), $sampled(exp_last),
                            $sampled(m_tdata), $sampled(m_tlast)));
    end

    initial begin
        void'($urandom(SEED));
        cycle_cnt         = 0;
        last_write        = -1;
        pc                = '0;
        instr             = '0;
        en                = 1'b0;
        ctrl_addr         = TRIG_START_EN;
        ctrl_wdata        = '0;
        ctrl_write_enable = 1'b0;
        m_tready          = 1'b1;
        ready_mode        = READY_HIGH;
        rst_n             = 1'b0;
        exp_valid         = 1'b0;
        exp_data          = '0;
        exp_mask          = '0;
        exp_last          = 1'b0;
        m_en              = 1'b0;
        m_start_en        = 1'b0;
        m_end_en          = 1'b0;
        m_start_addr      = '0;
        m_end_addr        = '1;
        m_lo_en           = 1'b0;
        m_hi_en           = 1'b0;
        m_lo              = '0;
        m_hi              = '1;
        m_started         = 1'b0;
        m_ended           = 1'b0;
        test_name         = "reset";
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        tick();

        test_name = "plain_trace";
        en   = 1'b1;
        m_en = 1'b1;
        run_program(32'h100, 8, 1'b0, MAX_PCS);
        wait_drain();

        test_name = "range_both";
        write_reg(RANGE_LO, 32'h308, 1);
        write_reg(RANGE_HI, 32'h318, 1);
        write_reg(RANGE_LO_EN, 32'h1, 1);
        write_reg(RANGE_HI_EN, 32'h1, 1);
        run_program(32'h300, 10, 1'b0, MAX_PCS);
        wait_drain();
        test_name = "range_lo_only";
        write_reg(RANGE_HI_EN, 32'h0, 1);
        run_program(32'h300, 10, 1'b0, MAX_PCS);
        wait_drain();
        test_name = "range_hi_only";
        write_reg(RANGE_LO_EN, 32'h0, 1);
        write_reg(RANGE_HI_EN, 32'h1, 1);
        run_program(32'h300, 10, 1'b0, MAX_PCS);
        wait_drain();
        write_reg(RANGE_HI_EN, 32'h0, 1);

        test_name = "enable_low";
        en   = 1'b0;
        m_en = 1'b0;
        run_program(32'h400, 6, 1'b0, MAX_PCS);
        wait_drain();
        en   = 1'b1;
        m_en = 1'b1;

        test_name = "triggers";
        write_reg(TRIG_START_ADDR, 32'h208, 3);
        write_reg(TRIG_END_ADDR, 32'h21c, 3);
        write_reg(TRIG_START_EN, 32'h1, 3);
        write_reg(TRIG_END_EN, 32'h1, 3);
        run_program(32'h200, 10, 1'b0, MAX_PCS);
        wait_drain();
        test_name = "trigger_resume";
        run_program(32'h200, 10, 1'b0, MAX_PCS);
        wait_drain();
        write_reg(TRIG_START_EN, 32'h0, 1);
        write_reg(TRIG_END_EN, 32'h0, 1);

        test_name = "wfi_stop";
        run_program(32'h500, 5, 1'b1, MAX_PCS);
        wait_drain();

        test_name  = "backpressure";
        ready_mode = READY_RANDOM;
        run_program(32'h600, 12, 1'b0, MAX_PCS);
        wait_drain();
        ready_mode = READY_HIGH;
        repeat (2) tick();
        check_overflow(1'b0);

        test_name  = "overflow";
        ready_mode = READY_LOW;
        run_program(32'h700, 12, 1'b0, FIFO_DEPTH);
        check_overflow(1'b1);
        ready_mode = READY_HIGH;
        wait_drain();
        repeat (IDLE_CYCLES) tick();

        if (exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected records were left over", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
trace_monitor_pkg.sv
ctrl_regs.sv
pc_tracker.sv
trace_gate.sv
delta_timer.sv
trace_fifo.sv
trace_monitor.sv
tb_trace_monitor.sv
